// ==== src/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t RESET_PC_DEFAULT = 32'hbfc0_0000;

    // ------------------------------
    // instruction encodings
    // ------------------------------
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    // one instruction word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            opcode_e  opcode;
            reg_idx_t rs;
            reg_idx_t rt;
            reg_idx_t rd;
            logic [4:0] shamt;
            funct_e   funct;
        } r;
        struct packed {
            opcode_e     opcode;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    // ------------------------------
    // stage boundaries
    // ------------------------------
    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        alu_op_e  alu_op;
        word_t    operand_a;
        word_t    operand_b;
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_read;
    } mem_wb_t;

    // write still in flight, seen by the decode interlock
    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        logic     reg_write;
    } pending_t;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             ds_allowin,
    input  mips_pkg::word_t  inst_sram_rdata,
    output logic             fs_valid,
    output mips_pkg::if_id_t fs_to_ds,
    output logic             inst_sram_en,
    output mips_pkg::word_t  inst_sram_addr,
    output logic [3:0]       inst_sram_wen,
    output mips_pkg::word_t  inst_sram_wdata
);
    import mips_pkg::*;

    // pc of the word now coming back from the sram
    word_t fs_pc;
    logic  fs_go;

    assign fs_go = fs_valid && ds_allowin;

    // advance only when decode takes the word, otherwise read it again
    assign inst_sram_addr  = fs_go ? fs_pc + 32'd4 : fs_pc;
    assign inst_sram_en    = ~reset;
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            fs_pc    <= RESET_PC;
        end else begin
            fs_valid <= 1'b1;
            fs_pc    <= inst_sram_addr;
        end
    end

    assign fs_to_ds.pc   = fs_pc;
    assign fs_to_ds.inst = inst_sram_rdata;

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_valid,
    input  mips_pkg::if_id_t   fs_to_ds,
    input  logic               es_allowin,
    input  mips_pkg::pending_t es_pending,
    input  mips_pkg::pending_t ms_pending,
    input  mips_pkg::pending_t ws_pending,
    input  mips_pkg::word_t    rf_rdata1,
    input  mips_pkg::word_t    rf_rdata2,
    output logic               ds_allowin,
    output logic               ds_valid,
    output mips_pkg::id_ex_t   ds_to_es,
    output mips_pkg::reg_idx_t rf_raddr1,
    output mips_pkg::reg_idx_t rf_raddr2
);
    import mips_pkg::*;

    if_id_t   ds_reg;
    logic     ds_full;
    instr_u   inst;
    word_t    imm_sext;
    word_t    imm_zext;
    alu_op_e  alu_op;
    word_t    operand_b;
    reg_idx_t dest;
    logic     reg_write, mem_read, mem_write;
    logic     use_rs, use_rt;
    logic     hazard;

    // true when an older stage will still write src
    function automatic logic pending_hit(pending_t p, reg_idx_t src);
        return p.valid && p.reg_write && (src != 5'd0) && (p.dest == src);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_full <= 1'b0;
        end else if (ds_allowin) begin
            ds_full <= fs_valid;
        end
        if (fs_valid && ds_allowin) begin
            ds_reg <= fs_to_ds;
        end
    end

    assign inst     = ds_reg.inst;
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};
    assign imm_zext = {16'h0000, inst.i.imm};

    assign rf_raddr1 = inst.r.rs;
    assign rf_raddr2 = inst.r.rt;

    // ------------------------------
    // control decode
    // ------------------------------
    always_comb begin
        alu_op    = ALU_ADD;
        operand_b = rf_rdata2;
        dest      = inst.i.rt;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_rs    = 1'b0;
        use_rt    = 1'b0;
        case (inst.i.opcode)
            OP_SPECIAL: begin
                dest      = inst.r.rd;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                reg_write = 1'b1;
                case (inst.r.funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLTU:  alu_op = ALU_SLTU;
                    // unknown funct retires as a nop
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                operand_b = imm_sext;
                use_rs    = 1'b1;
                reg_write = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                operand_b = imm_zext;
                reg_write = 1'b1;
            end
            OP_LW: begin
                operand_b = imm_sext;
                use_rs    = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                operand_b = imm_sext;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    // ------------------------------
    // raw interlock, no forwarding
    // ------------------------------
    assign hazard = (use_rs && (pending_hit(es_pending, inst.r.rs)
                             || pending_hit(ms_pending, inst.r.rs)
                             || pending_hit(ws_pending, inst.r.rs)))
                 || (use_rt && (pending_hit(es_pending, inst.r.rt)
                             || pending_hit(ms_pending, inst.r.rt)
                             || pending_hit(ws_pending, inst.r.rt)));

    assign ds_valid   = ds_full && !hazard;
    assign ds_allowin = !ds_full || (!hazard && es_allowin);

    assign ds_to_es = '{
        pc:         ds_reg.pc,
        alu_op:     alu_op,
        operand_a:  rf_rdata1,
        operand_b:  operand_b,
        store_data: rf_rdata2,
        dest:       dest,
        reg_write:  reg_write,
        mem_read:   mem_read,
        mem_write:  mem_write
    };

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  mips_pkg::reg_idx_t raddr1,
    input  mips_pkg::reg_idx_t raddr2,
    input  logic               we,
    input  mips_pkg::reg_idx_t waddr,
    input  mips_pkg::word_t    wdata,
    output mips_pkg::word_t    rdata1,
    output mips_pkg::word_t    rdata2
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero always reads back as 0
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_valid,
    input  mips_pkg::id_ex_t   ds_to_es,
    input  logic               ms_allowin,
    output logic               es_allowin,
    output logic               es_valid,
    output mips_pkg::ex_mem_t  es_to_ms,
    output mips_pkg::pending_t es_pending
);
    import mips_pkg::*;

    id_ex_t es_reg;
    word_t  alu_result;

    // single-cycle alu, so ready whenever full
    assign es_allowin = !es_valid || ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
        if (ds_valid && es_allowin) begin
            es_reg <= ds_to_es;
        end
    end

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (es_reg.alu_op)
            ALU_ADD:  alu_result = es_reg.operand_a + es_reg.operand_b;
            ALU_SUB:  alu_result = es_reg.operand_a - es_reg.operand_b;
            ALU_AND:  alu_result = es_reg.operand_a & es_reg.operand_b;
            ALU_OR:   alu_result = es_reg.operand_a | es_reg.operand_b;
            ALU_XOR:  alu_result = es_reg.operand_a ^ es_reg.operand_b;
            ALU_SLT:  alu_result = {31'd0, $signed(es_reg.operand_a) < $signed(es_reg.operand_b)};
            ALU_SLTU: alu_result = {31'd0, es_reg.operand_a < es_reg.operand_b};
            ALU_LUI:  alu_result = {es_reg.operand_b[15:0], 16'h0000};
            default:  alu_result = '0;
        endcase
    end

    // lw/sw: the add result is the byte address
    assign es_to_ms = '{
        pc:         es_reg.pc,
        alu_result: alu_result,
        store_data: es_reg.store_data,
        dest:       es_reg.dest,
        reg_write:  es_reg.reg_write,
        mem_read:   es_reg.mem_read,
        mem_write:  es_reg.mem_write
    };

    assign es_pending = '{valid: es_valid, dest: es_reg.dest, reg_write: es_reg.reg_write};

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_valid,
    input  mips_pkg::ex_mem_t  es_to_ms,
    input  logic               ws_allowin,
    output logic               ms_allowin,
    output logic               ms_valid,
    output mips_pkg::mem_wb_t  ms_to_ws,
    output mips_pkg::pending_t ms_pending,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output mips_pkg::word_t    data_sram_addr,
    output mips_pkg::word_t    data_sram_wdata
);
    import mips_pkg::*;

    ex_mem_t ms_reg;

    assign ms_allowin = !ms_valid || ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_valid;
        end
        if (es_valid && ms_allowin) begin
            ms_reg <= es_to_ms;
        end
    end

    // word access only, load data comes back in writeback
    assign data_sram_en    = ms_valid && (ms_reg.mem_read || ms_reg.mem_write);
    assign data_sram_wen   = (ms_valid && ms_reg.mem_write) ? 4'hf : 4'h0;
    assign data_sram_addr  = ms_reg.alu_result;
    assign data_sram_wdata = ms_reg.store_data;

    assign ms_to_ws = '{
        pc:        ms_reg.pc,
        result:    ms_reg.alu_result,
        dest:      ms_reg.dest,
        reg_write: ms_reg.reg_write,
        mem_read:  ms_reg.mem_read
    };

    assign ms_pending = '{valid: ms_valid, dest: ms_reg.dest, reg_write: ms_reg.reg_write};

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_valid,
    input  mips_pkg::mem_wb_t  ms_to_ws,
    input  mips_pkg::word_t    data_sram_rdata,
    output logic               ws_allowin,
    output mips_pkg::pending_t ws_pending,
    output logic               rf_we,
    output mips_pkg::reg_idx_t rf_waddr,
    output mips_pkg::word_t    rf_wdata,
    output mips_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output mips_pkg::reg_idx_t debug_wb_rf_wnum,
    output mips_pkg::word_t    debug_wb_rf_wdata
);
    import mips_pkg::*;

    mem_wb_t ws_reg;
    logic    ws_valid;

    // last stage, it retires every cycle
    assign ws_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
        if (ms_valid) begin
            ws_reg <= ms_to_ws;
        end
    end

    assign rf_we    = ws_valid && ws_reg.reg_write && (ws_reg.dest != 5'd0);
    assign rf_waddr = ws_reg.dest;
    assign rf_wdata = ws_reg.mem_read ? data_sram_rdata : ws_reg.result;

    assign ws_pending = '{valid: ws_valid, dest: ws_reg.dest, reg_write: ws_reg.reg_write};

    // ------------------------------
    // debug trace
    // ------------------------------
    assign debug_wb_pc       = ws_reg.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_reg.dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,

    // instruction sram
    output logic            inst_sram_en,
    output logic [3:0]      inst_sram_wen,
    output mips_pkg::word_t inst_sram_addr,
    output mips_pkg::word_t inst_sram_wdata,
    input  mips_pkg::word_t inst_sram_rdata,

    // data sram
    output logic            data_sram_en,
    output logic [3:0]      data_sram_wen,
    output mips_pkg::word_t data_sram_addr,
    output mips_pkg::word_t data_sram_wdata,
    input  mips_pkg::word_t data_sram_rdata,

    // retirement trace
    output mips_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output mips_pkg::reg_idx_t debug_wb_rf_wnum,
    output mips_pkg::word_t    debug_wb_rf_wdata
);
    import mips_pkg::*;

    // stage handshake levels
    logic fs_valid, ds_allowin;
    logic ds_valid, es_allowin;
    logic es_valid, ms_allowin;
    logic ms_valid, ws_allowin;

    if_id_t  fs_to_ds;
    id_ex_t  ds_to_es;
    ex_mem_t es_to_ms;
    mem_wb_t ms_to_ws;

    pending_t es_pending;
    pending_t ms_pending;
    pending_t ws_pending;

    // register file ports
    reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
    word_t    rf_rdata1, rf_rdata2, rf_wdata;
    logic     rf_we;

    fetch_stage #(.RESET_PC(RESET_PC)) i_fetch_stage (.*);

    decode_stage i_decode_stage (.*);

    reg_file i_reg_file (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    execute_stage i_execute_stage (.*);

    memory_stage i_memory_stage (.*);

    writeback_stage i_writeback_stage (.*);

endmodule

`default_nettype wire

// ==== testbench/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::RESET_PC_DEFAULT,
    parameter int              PROG_LEN = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_sram_en,
    input  logic [3:0]         inst_sram_wen,
    input  mips_pkg::word_t    inst_sram_wdata,
    input  mips_pkg::word_t    debug_wb_pc,
    input  logic [3:0]         debug_wb_rf_wen,
    input  mips_pkg::reg_idx_t debug_wb_rf_wnum,
    input  mips_pkg::word_t    debug_wb_rf_wdata,
    input  logic               data_sram_en,
    input  logic [3:0]         data_sram_wen,
    input  mips_pkg::word_t    data_sram_addr,
    input  mips_pkg::word_t    data_sram_wdata
);
    import mips_pkg::*;

    // program image filled by the testbench top
    logic [31:0] prog [PROG_LEN];
    logic [31:0] regs [32];
    logic [31:0] dmem [256];
    logic [31:0] model_pc;
    logic [31:0] last_pc;
    logic [4:0]  prev_dest;
    logic        retire;
    int          retired;
    int          stores;
    int          checks [7];
    int          errors [7];

    // stores seen on the data sram that wait for their retirement
    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    logic [3:0]  st_wen_q  [$];

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h0;
        end
        for (int i = 0; i < 7; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        model_pc  = RESET_PC;
        prev_dest = 5'd0;
        retired   = 0;
        stores    = 0;
    end

    task automatic check_value(int beh, string name, logic [31:0] got, logic [31:0] exp);
        checks[beh]++;
        if (got !== exp) begin
            errors[beh]++;
            $display("MISMATCH %s: got %08h expected %08h at pc %08h", name, got, exp, model_pc);
        end
    endtask

    // ------------------------------
    // instruction-level model
    // ------------------------------
    task automatic step_model();
        logic [31:0] off;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] res;
        logic [31:0] addr;
        logic [5:0]  op;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  dest;
        logic        writes;
        logic        use_rs;
        logic        use_rt;
        int          beh;

        off  = (model_pc - RESET_PC) >> 2;
        inst = (off < PROG_LEN) ? prog[off] : 32'h0;
        check_value(1, "debug_wb_pc", debug_wb_pc, model_pc);

        op     = inst[31:26];
        rs     = inst[25:21];
        rt     = inst[20:16];
        rd     = inst[15:11];
        funct  = inst[5:0];
        a      = regs[rs];
        b      = regs[rt];
        sext   = {{16{inst[15]}}, inst[15:0]};
        addr   = a + sext;
        res    = 32'h0;
        dest   = 5'd0;
        writes = 1'b0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (op)
            6'h00: begin
                dest   = rd;
                writes = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
                case (funct)
                    6'h21:   res = a + b;
                    6'h23:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h26:   res = a ^ b;
                    6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            6'h09: begin
                dest   = rt;
                writes = 1'b1;
                use_rs = 1'b1;
                res    = addr;
            end
            6'h0f: begin
                dest   = rt;
                writes = 1'b1;
                res    = {inst[15:0], 16'h0000};
            end
            6'h23: begin
                dest   = rt;
                writes = 1'b1;
                use_rs = 1'b1;
                res    = dmem[addr[9:2]];
            end
            6'h2b: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            default: ;
        endcase

        // sort the check into the behavior it shows
        if (writes && dest == 5'd0) begin
            beh = 5;
        end else if (op == 6'h23 || op == 6'h2b) begin
            beh = 4;
        end else if (prev_dest != 5'd0
                     && ((use_rs && rs == prev_dest) || (use_rt && rt == prev_dest))) begin
            beh = 3;
        end else begin
            beh = 2;
        end

        if (writes && dest != 5'd0) begin
            check_value(beh, "debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'hf);
            check_value(beh, "debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, {27'd0, dest});
            check_value(beh, "debug_wb_rf_wdata", debug_wb_rf_wdata, res);
            regs[dest] = res;
        end else begin
            check_value(beh, "debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0);
        end

        if (op == 6'h2b) begin
            if (st_addr_q.size() == 0) begin
                checks[4]++;
                errors[4]++;
                $display("store at pc %08h retired without any write on the data sram", model_pc);
            end else begin
                check_value(4, "data_sram_addr", st_addr_q.pop_front(), addr);
                check_value(4, "data_sram_wdata", st_data_q.pop_front(), b);
                check_value(4, "data_sram_wen", {28'd0, st_wen_q.pop_front()}, 32'hf);
            end
            dmem[addr[9:2]] = b;
        end else if (st_addr_q.size() != 0) begin
            checks[4]++;
            errors[4]++;
            $display("data sram write seen that no store instruction accounts for, pc %08h",
                     model_pc);
            st_addr_q.delete();
            st_data_q.delete();
            st_wen_q.delete();
        end

        prev_dest = writes ? dest : 5'd0;
        model_pc  = model_pc + 32'd4;
        retired++;
    endtask

    // sampled at the rising edge before any register moves
    always @(posedge clk) begin
        // the instruction port only reads
        check_value(6, "inst_sram_wen", {28'd0, inst_sram_wen}, 32'h0);
        check_value(6, "inst_sram_wdata", inst_sram_wdata, 32'h0);
        if (reset) begin
            check_value(6, "inst_sram_en", {31'd0, inst_sram_en}, 32'h0);
            last_pc = debug_wb_pc;
        end else begin
            retire = (debug_wb_pc !== last_pc) || (debug_wb_rf_wen != 4'h0);
            if (retired == 0 && stores == 0 && debug_wb_pc === last_pc) begin
                check_value(6, "debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0);
                check_value(6, "data_sram_en", {31'd0, data_sram_en}, 32'h0);
                check_value(6, "data_sram_wen", {28'd0, data_sram_wen}, 32'h0);
            end
            if (retire) begin
                step_model();
            end
            last_pc = debug_wb_pc;
            if (data_sram_en && data_sram_wen != 4'h0) begin
                st_addr_q.push_back(data_sram_addr);
                st_data_q.push_back(data_sram_wdata);
                st_wen_q.push_back(data_sram_wen);
                stores++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    localparam word_t RESET_PC   = RESET_PC_DEFAULT;
    localparam int    PROG_LEN   = 256;
    localparam int    CLK_PERIOD = 100;
    // five cycles per instruction covers the worst interlock stall
    localparam int    TIMEOUT_NS = PROG_LEN * 5 * CLK_PERIOD + 50 * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    word_t       inst_sram_addr;
    word_t       inst_sram_wdata;
    word_t       inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    word_t       data_sram_addr;
    word_t       data_sram_wdata;
    word_t       data_sram_rdata;
    word_t       debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    reg_idx_t    debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;

    integer      seed;
    logic [31:0] imem [PROG_LEN];
    logic [31:0] dmem [256];
    logic [31:0] inst_addr_q;
    logic [31:0] data_rdata_q;

    mips_core #(.RESET_PC(RESET_PC)) i_mips_core (.*);

    core_checker #(.RESET_PC(RESET_PC), .PROG_LEN(PROG_LEN)) i_core_checker (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_wdata   (inst_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // sram models
    // ------------------------------
    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < PROG_LEN) ? imem[idx] : 32'h0;
    endfunction

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_addr_q <= inst_sram_addr;
        end
        if (data_sram_en) begin
            if (data_sram_wen != 4'h0) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_rdata_q <= dmem[data_sram_addr[9:2]];
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata = fetch_word(inst_addr_q);
        data_sram_rdata = data_rdata_q;
    end

    // registers stay in r0..r7 so dependencies come often
    function automatic logic [31:0] random_instr();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  funct;
        kind = {$random(seed)} % 11;
        rs   = 5'({$random(seed)} % 8);
        rt   = 5'({$random(seed)} % 8);
        rd   = 5'({$random(seed)} % 8);
        imm  = 16'($random(seed));
        case (kind)
            0:       funct = 6'h21;
            1:       funct = 6'h23;
            2:       funct = 6'h24;
            3:       funct = 6'h25;
            4:       funct = 6'h26;
            5:       funct = 6'h2a;
            default: funct = 6'h2b;
        endcase
        case (kind)
            7:       return {6'h09, rs, rt, imm};
            8:       return {6'h0f, 5'd0, rt, imm};
            // word offsets below 1 KiB from $zero
            9:       return {6'h23, 5'd0, rt, 6'd0, imm[7:0], 2'b00};
            10:      return {6'h2b, 5'd0, rt, 6'd0, imm[7:0], 2'b00};
            default: return {6'h00, rs, rt, rd, 5'd0, funct};
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] word;
        for (int k = 0; k < PROG_LEN; k++) begin
            if (k < 7) begin
                word = {6'h09, 5'd0, 5'(k + 1), 16'($random(seed))};
            end else begin
                word = random_instr();
            end
            imem[k] = word;
            i_core_checker.prog[k] = word;
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = 32'h0;
        end
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: only %0d of %0d instructions retired in time",
                 i_core_checker.retired, PROG_LEN);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        string names [7];
        int    total_checks;
        int    total_errors;
        names[1] = "program order";
        names[2] = "alu and lui results";
        names[3] = "dependent instructions";
        names[4] = "loads and stores";
        names[5] = "register zero";
        names[6] = "quiet after reset";
        seed            = 8049;
        reset           = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        inst_addr_q     = RESET_PC;
        data_rdata_q    = 32'h0;
        build_program();
        repeat (4) @(negedge clk);
        reset = 1'b0;

        while (i_core_checker.retired < PROG_LEN) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        total_checks = 0;
        total_errors = 0;
        for (int b = 1; b < 7; b++) begin
            $display("behavior %0d, %s: %0d checks, %0d errors", b, names[b],
                     i_core_checker.checks[b], i_core_checker.errors[b]);
            total_checks += i_core_checker.checks[b];
            total_errors += i_core_checker.errors[b];
        end
        $display("%0d instructions retired, %0d checks, %0d errors",
                 i_core_checker.retired, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_pipe.f ====
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/writeback_stage.sv
src/mips_core.sv
testbench/core_checker.sv
testbench/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the MIPS pipeline testbench with Verilator, run it and check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
    -f mips_pipe.f \
    --top-module tb_mips_core \
    --Mdir obj_dir \
    -o sim_tb_mips_core

./obj_dir/sim_tb_mips_core | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
